/* bench/core_tb_tests.svh */
localparam logic [6:0] opc_op        = 7'b0110011;
localparam logic [6:0] opc_op_imm    = 7'b0010011;
localparam logic [6:0] opc_op_32     = 7'b0111011;
localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
localparam logic [6:0] opc_lui       = 7'b0110111;
localparam logic [6:0] opc_auipc     = 7'b0010111;
localparam logic [31:0] ebreak_word  = 32'h0010_0073;

function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                      input int f3, input int rd, input logic [6:0] opc);
    enc_r = {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), opc};
endfunction

function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                      input int rd, input logic [6:0] opc);
    enc_i = {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
endfunction

function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] opc);
    enc_u = {20'(imm), 5'(rd), opc};
endfunction

// ############################################################################
// reference model, runs prog_q up to ebreak.
// ############################################################################

task automatic model_program();
    logic [63:0] x [32];
    logic [63:0] pc;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] v;
    logic [31:0] w;
    logic [31:0] ins;
    logic        alt;
    ex_wb_t      e;
    pc = start_pc;
    expect_q.delete();
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    for (int i = 0; i < prog_q.size(); i++) begin
        ins = prog_q[i];
        if (ins == ebreak_word) begin
            break;
        end
        a   = x[ins[19:15]];
        b   = ins[5] ? x[ins[24:20]] : {{52{ins[31]}}, ins[31:20]};
        alt = ins[30] && (ins[5] || ins[14:12] == 3'd5);
        v   = '0;
        w   = '0;
        if (ins[6:0] == opc_lui) begin
            v = {{32{ins[31]}}, ins[31:12], 12'b0};
        end else if (ins[6:0] == opc_auipc) begin
            v = pc + {{32{ins[31]}}, ins[31:12], 12'b0};
        end else if (ins[3]) begin
            case (ins[14:12])
                3'd0: w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
                3'd1: w = a[31:0] << b[4:0];
                default: w = alt ? 32'($signed(a[31:0]) >>> b[4:0]) : a[31:0] >> b[4:0];
            endcase
            v = {{32{w[31]}}, w};
        end else begin
            case (ins[14:12])
                3'd0: v = alt ? a - b : a + b;
                3'd1: v = a << b[5:0];
                3'd2: v = {63'b0, $signed(a) < $signed(b)};
                3'd3: v = {63'b0, a < b};
                3'd4: v = a ^ b;
                3'd5: v = alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
                3'd6: v = a | b;
                default: v = a & b;
            endcase
        end
        if (ins[11:7] != 5'd0) begin
            x[ins[11:7]] = v;
            e        = '0;
            e.valid  = 1'b1;
            e.pc     = pc;
            e.rd_ena = 1'b1;
            e.rd     = ins[11:7];
            e.result = v;
            expect_q.push_back(e);
        end
        pc = pc + 64'd4;
    end
endtask

// ############################################################################
// program run and checks.
// ############################################################################

task automatic reset_dut();
    @(posedge clk);
    reset <= 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    retire_q.delete();
endtask

task automatic start_program();
    for (int i = 0; i < mem_words; i++) begin
        mem[i] = (i < prog_q.size()) ? prog_q[i] : fill_word(start_pc + 64'(4 * i));
    end
    model_program();
    reset_dut();
endtask

task automatic finish_program(input string name, input int start_errors);
    int  cycles;
    logic late_req;
    cycles = 0;
    while (!(halted && retire_q.size() >= expect_q.size()) && cycles < timeout_cycles) begin
        @(posedge clk);
        cycles++;
    end
    if (cycles >= timeout_cycles) begin
        report_error(name, "timed out waiting for halt and retires");
    end
    // no request may start after halt.
    late_req = 1'b0;
    for (int i = 0; i < 40; i++) begin
        @(negedge clk);
        late_req = late_req | wb_cyc;
    end
    check_flag(name, "halted", 1'b1, halted);
    check_flag(name, "request after halt", 1'b0, late_req);
    if (retire_q.size() != expect_q.size()) begin
        report_error(name, $sformatf("retired %0d instructions, model expects %0d",
                                     retire_q.size(), expect_q.size()));
    end
    for (int i = 0; i < retire_q.size() && i < expect_q.size(); i++) begin
        check_retire(name, expect_q[i], retire_q[i]);
    end
    tests_run++;
    if (errors == start_errors) begin
        $display("test %s: ok, %0d retires", name, retire_q.size());
    end else begin
        tests_failed++;
        $display("test %s: failed with %0d errors", name, errors - start_errors);
    end
endtask

task automatic test_reset_first_fetch();
    int start;
    int cycles;
    start  = errors;
    prog_q = {enc_i(5, 0, 0, 1, opc_op_imm), ebreak_word};
    start_program();
    @(negedge clk);
    check_flag("reset_first_fetch", "wb_cyc", 1'b0, wb_cyc);
    check_flag("reset_first_fetch", "wb_stb", 1'b0, wb_stb);
    check_flag("reset_first_fetch", "retire_valid", 1'b0, retire_valid);
    check_flag("reset_first_fetch", "halted", 1'b0, halted);
    cycles = 0;
    while (!wb_cyc && cycles < 20) begin
        @(negedge clk);
        cycles++;
    end
    if (!wb_cyc) begin
        report_error("reset_first_fetch", "no first request after reset");
    end
    check_addr("reset_first_fetch", start_pc, wb_adr);
    check_flag("reset_first_fetch", "wb_we", 1'b0, wb_we);
    finish_program("reset_first_fetch", start);
endtask

task automatic test_imm_ops();
    int start;
    start  = errors;
    prog_q = {enc_i(-7, 0, 0, 1, opc_op_imm), enc_i(12'h5a5, 1, 4, 2, opc_op_imm),
              enc_i(12'h0f0, 1, 6, 3, opc_op_imm), enc_i(12'h3c, 2, 7, 4, opc_op_imm),
              enc_i(13, 1, 1, 5, opc_op_imm), enc_i(12'h400 | 4, 1, 5, 6, opc_op_imm),
              enc_i(-3, 1, 2, 7, opc_op_imm), enc_i(-3, 1, 3, 8, opc_op_imm), ebreak_word};
    start_program();
    finish_program("imm_ops", start);
endtask

function automatic void chain_program();
    prog_q = {enc_i(7, 0, 0, 1, opc_op_imm), enc_i(-3, 0, 0, 2, opc_op_imm),
              enc_r(0, 2, 1, 0, 3, opc_op), enc_r(32, 1, 3, 0, 4, opc_op),
              enc_r(0, 2, 4, 1, 5, opc_op), enc_r(0, 4, 5, 4, 6, opc_op),
              enc_r(0, 3, 6, 2, 7, opc_op), enc_r(0, 1, 2, 3, 8, opc_op),
              enc_r(0, 6, 5, 6, 9, opc_op), enc_r(0, 9, 2, 7, 10, opc_op),
              enc_r(0, 1, 10, 5, 11, opc_op), enc_r(32, 1, 2, 5, 12, opc_op), ebreak_word};
endfunction

task automatic test_dependent_chains();
    int start;
    start = errors;
    chain_program();
    start_program();
    finish_program("dependent_chains", start);
endtask

task automatic test_word_forms();
    int start;
    start  = errors;
    prog_q = {enc_u(20'h80000, 1, opc_lui), enc_u(20'h12345, 2, opc_auipc),
              enc_i(-1, 1, 0, 3, opc_op_imm_32), enc_r(0, 3, 3, 0, 4, opc_op_32),
              enc_r(32, 3, 1, 0, 5, opc_op_32), enc_r(0, 2, 3, 1, 6, opc_op_32),
              enc_r(32, 2, 4, 5, 7, opc_op_32), enc_i(9, 0, 0, 0, opc_op_imm),
              enc_r(0, 2, 1, 0, 0, opc_op), ebreak_word};
    start_program();
    finish_program("word_forms", start);
endtask

task automatic test_random_waits();
    int start;
    start        = errors;
    random_waits = 1'b1;
    chain_program();
    start_program();
    finish_program("random_waits", start);
    random_waits = 1'b0;
endtask

/* bench/core_tb.sv */
`timescale 1ns/1ps

module core_tb;
    import core_pkg::*;

    localparam logic [xlen-1:0] start_pc = 64'h0000_0000_8000_0000;
    localparam int mem_words      = 256;
    localparam int timeout_cycles = 4000;

    logic                   clk;
    logic                   reset;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [xlen-1:0]        wb_adr;
    logic                   wb_ack   = 1'b0;
    logic [ilen-1:0]        wb_dat_i = '0;
    logic                   retire_valid;
    logic [xlen-1:0]        retire_pc;
    reg_addr_t              retire_rd;
    logic [xlen-1:0]        retire_data;
    logic                   halted;

    logic [ilen-1:0] mem [0:mem_words-1];
    logic [1:0]      waits = 2'd0;
    logic            random_waits;
    ex_wb_t          retire_q [$];
    ex_wb_t          expect_q [$];
    logic [ilen-1:0] prog_q [$];
    int              errors;
    int              tests_run;
    int              tests_failed;

    core_top #(
        .reset_pc (start_pc)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_ack       (wb_ack),
        .wb_dat_i     (wb_dat_i),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ########################################################################
    // wishbone memory and retire monitor.
    // ########################################################################

    // addi x0, x0 with an immediate folded from the address.
    function automatic logic [ilen-1:0] fill_word(input logic [xlen-1:0] adr);
        logic [11:0] fold;
        fold = adr[11:0] ^ adr[23:12] ^ adr[35:24] ^ adr[47:36] ^ adr[59:48]
             ^ {8'b0, adr[63:60]};
        fill_word = {fold, 5'd0, 3'b000, 5'd0, 7'b0010011};
    endfunction

    function automatic logic [ilen-1:0] mem_word(input logic [xlen-1:0] adr);
        logic [xlen-1:0] idx;
        idx = (adr - start_pc) >> 2;
        if (idx < 64'(mem_words)) begin
            mem_word = mem[idx[7:0]];
        end else begin
            mem_word = fill_word(adr);
        end
    endfunction

    always @(posedge clk) begin
        if (reset || wb_ack) begin
            wb_ack <= 1'b0;
            waits  <= random_waits ? 2'($urandom % 4) : 2'd0;
        end else if (wb_cyc && wb_stb) begin
            if (waits == 2'd0) begin
                wb_ack   <= 1'b1;
                wb_dat_i <= mem_word(wb_adr);
            end else begin
                waits <= waits - 2'd1;
            end
        end
    end

    always @(posedge clk) begin : retire_monitor
        ex_wb_t r;
        r        = '0;
        r.valid  = 1'b1;
        r.pc     = retire_pc;
        r.rd_ena = 1'b1;
        r.rd     = retire_rd;
        r.result = retire_data;
        if (!reset && retire_valid) begin
            retire_q.push_back(r);
        end
    end

    // ########################################################################
    // compare tasks.
    // ########################################################################

    task automatic check_retire(input string name, input ex_wb_t exp, input ex_wb_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected pc %h rd %0d data %h, actual pc %h rd %0d data %h",
                     name, exp.pc, exp.rd, exp.result, act.pc, act.rd, act.result);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch %s: %s expected %b, actual %b", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [xlen-1:0] exp,
                              input logic [xlen-1:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: wb_adr expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_error(input string name, input string msg);
        $display("Error %s: %s", name, msg);
        errors++;
    endtask

    `include "core_tb_tests.svh"

    initial begin
        void'($urandom(32'h0753a3f0));
        reset        = 1'b1;
        random_waits = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_imm_ops();
        // reset is checked coming out of a halted run.
        test_reset_first_fetch();
        test_dependent_chains();
        test_word_forms();
        test_random_waits();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module core_tb -f tb.f -o core_tb_sim \
    && ./obj_dir/core_tb_sim | tee sim.log \
    || exit 1

grep -qx '>>> PASS' sim.log && exit 0 || exit 1

/* source/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute (
    input  core_pkg::id_ex_t  ex_q,
    input  core_pkg::ex_wb_t  wb_q,
    output core_pkg::ex_wb_t  result
);
    import core_pkg::*;

    logic            fwd_ok;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] raw;

    // ########################################################################
    // forwarding from the writeback register.
    // ########################################################################

    assign fwd_ok = wb_q.valid && wb_q.rd_ena && (wb_q.rd != '0);

    // immediate forms carry source index zero, so never match.
    assign op_a = (fwd_ok && (ex_q.rs1 == wb_q.rd)) ? wb_q.result : ex_q.op1;
    assign op_b = (fwd_ok && (ex_q.rs2 == wb_q.rd)) ? wb_q.result : ex_q.op2;

    // ########################################################################
    // alu.
    // ########################################################################

    always_comb begin
        raw = '0;
        case (ex_q.op)
            op_add, op_addw: begin
                raw = op_a + op_b;
            end
            op_sub, op_subw: begin
                raw = op_a - op_b;
            end
            op_sll:  raw = op_a << op_b[5:0];
            op_slt:  raw = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            op_sltu: raw = {{(xlen-1){1'b0}}, op_a < op_b};
            op_xor:  raw = op_a ^ op_b;
            op_srl:  raw = op_a >> op_b[5:0];
            op_sra:  raw = $signed(op_a) >>> op_b[5:0];
            op_or:   raw = op_a | op_b;
            op_and:  raw = op_a & op_b;
            // word shifts use the low word and a five bit amount.
            op_sllw: raw = {32'b0, op_a[31:0] << op_b[4:0]};
            op_srlw: raw = {32'b0, op_a[31:0] >> op_b[4:0]};
            op_sraw: raw = {32'b0, $signed(op_a[31:0]) >>> op_b[4:0]};
            op_pass: raw = op_b;
            default: raw = '0;
        endcase
    end

    // ########################################################################
    // result payload.
    // ########################################################################

    always_comb begin
        result.valid  = ex_q.valid && ex_q.rd_ena;
        result.pc     = ex_q.pc;
        result.rd_ena = ex_q.rd_ena;
        result.rd     = ex_q.rd;
        if (ex_q.word) begin
            result.result = {{(xlen-32){raw[31]}}, raw[31:0]};
        end else begin
            result.result = raw;
        end
    end

endmodule

/* source/core_pkg.sv */
package core_pkg;

    // ########################################################################
    // widths and reset values.
    // ########################################################################

    localparam int xlen = 64;
    localparam int ilen = 32;

    localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;

    typedef logic [4:0] reg_addr_t;

    // ########################################################################
    // alu operations.
    // ########################################################################

    typedef enum logic [4:0] {
        op_add  = 5'd0,
        op_sub  = 5'd1,
        op_sll  = 5'd2,
        op_slt  = 5'd3,
        op_sltu = 5'd4,
        op_xor  = 5'd5,
        op_srl  = 5'd6,
        op_sra  = 5'd7,
        op_or   = 5'd8,
        op_and  = 5'd9,
        op_addw = 5'd10,
        op_subw = 5'd11,
        op_sllw = 5'd12,
        op_srlw = 5'd13,
        op_sraw = 5'd14,
        // lui result is operand two as is.
        op_pass = 5'd15
    } alu_op_t;

    // ########################################################################
    // stage payloads.
    // ########################################################################

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [ilen-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        alu_op_t         op;
        logic [xlen-1:0] op1;
        logic [xlen-1:0] op2;
        reg_addr_t       rs1;
        reg_addr_t       rs2;
        reg_addr_t       rd;
        logic            rd_ena;
        logic            word;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic            rd_ena;
        reg_addr_t       rd;
        logic [xlen-1:0] result;
    } ex_wb_t;

endpackage

/* source/core_top.sv */
`timescale 1ns/1ps

module core_top #(
    parameter logic [core_pkg::xlen-1:0] reset_pc = core_pkg::reset_pc
) (
    input  logic                       clk,
    input  logic                       reset,
    // wishbone classic master.
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic                       wb_we,
    output logic [core_pkg::xlen-1:0]  wb_adr,
    input  logic                       wb_ack,
    input  logic [core_pkg::ilen-1:0]  wb_dat_i,
    // retire trace.
    output logic                       retire_valid,
    output logic [core_pkg::xlen-1:0]  retire_pc,
    output core_pkg::reg_addr_t        retire_rd,
    output logic [core_pkg::xlen-1:0]  retire_data,
    output logic                       halted
);
    import core_pkg::*;

    if_id_t          fetch;
    if_id_t          fetch_q;
    id_ex_t          decoded;
    id_ex_t          ex_q;
    ex_wb_t          ex_result;
    ex_wb_t          wb_q;
    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) fetch_unit_i (
        .clk      (clk),
        .reset    (reset),
        .halt     (halted),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_ack   (wb_ack),
        .wb_dat_i (wb_dat_i),
        .fetch    (fetch)
    );

    // an instruction fetched after halt is discarded here.
    stage_reg #(.payload_t(if_id_t)) if_id_i (
        .clk    (clk),
        .reset  (reset),
        .bubble (halted),
        .d      (fetch),
        .q      (fetch_q)
    );

    decoder decoder_i (
        .clk      (clk),
        .reset    (reset),
        .fetch_q  (fetch_q),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .decoded  (decoded),
        .halted   (halted)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (wb_q.rd_ena),
        .rd_addr  (wb_q.rd),
        .rd_data  (wb_q.result)
    );

    stage_reg #(.payload_t(id_ex_t)) id_ex_i (
        .clk    (clk),
        .reset  (reset),
        .bubble (!decoded.valid),
        .d      (decoded),
        .q      (ex_q)
    );

    alu_execute alu_execute_i (
        .ex_q   (ex_q),
        .wb_q   (wb_q),
        .result (ex_result)
    );

    stage_reg #(.payload_t(ex_wb_t)) ex_wb_i (
        .clk    (clk),
        .reset  (reset),
        .bubble (!ex_result.valid),
        .d      (ex_result),
        .q      (wb_q)
    );

    assign retire_valid = wb_q.valid;
    assign retire_pc    = wb_q.pc;
    assign retire_rd    = wb_q.rd;
    assign retire_data  = wb_q.result;

endmodule

/* source/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  logic                       clk,
    input  logic                       reset,
    input  core_pkg::if_id_t           fetch_q,
    output core_pkg::reg_addr_t        rs1_addr,
    output core_pkg::reg_addr_t        rs2_addr,
    input  logic [core_pkg::xlen-1:0]  rs1_data,
    input  logic [core_pkg::xlen-1:0]  rs2_data,
    output core_pkg::id_ex_t           decoded,
    output logic                       halted
);
    import core_pkg::*;

    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_op_32     = 7'b0111011;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;

    localparam logic [ilen-1:0] ebreak_instr = 32'h0010_0073;

    logic [ilen-1:0] instr;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;
    logic            word_f3_ok;
    logic            known;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic            ebreak_now;
    logic            halt_q;

    // funct3 to operation, alt picks sub or sra.
    function automatic alu_op_t base_op(input logic [2:0] f3, input logic alt_sel);
        case (f3)
            3'b000:  base_op = alt_sel ? op_sub : op_add;
            3'b001:  base_op = op_sll;
            3'b010:  base_op = op_slt;
            3'b011:  base_op = op_sltu;
            3'b100:  base_op = op_xor;
            3'b101:  base_op = alt_sel ? op_sra : op_srl;
            3'b110:  base_op = op_or;
            default: base_op = op_and;
        endcase
    endfunction

    function automatic alu_op_t to_word(input alu_op_t op);
        case (op)
            op_add:  to_word = op_addw;
            op_sub:  to_word = op_subw;
            op_sll:  to_word = op_sllw;
            op_srl:  to_word = op_srlw;
            op_sra:  to_word = op_sraw;
            default: to_word = op;
        endcase
    endfunction

    assign instr      = fetch_q.instr;
    assign opcode     = instr[6:0];
    assign funct3     = instr[14:12];
    assign alt        = instr[30];
    assign word_f3_ok = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);
    assign imm_i      = {{(xlen-12){instr[31]}}, instr[31:20]};
    assign imm_u      = {{(xlen-32){instr[31]}}, instr[31:12], 12'b0};

    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // ########################################################################
    // halt on ebreak.
    // ########################################################################

    assign ebreak_now = fetch_q.valid && (instr == ebreak_instr);
    assign halted     = halt_q || ebreak_now;

    always_ff @(posedge clk) begin
        if (reset) begin
            halt_q <= 1'b0;
        end else if (ebreak_now) begin
            halt_q <= 1'b1;
        end
    end

    // ########################################################################
    // operation and operands.
    // ########################################################################

    always_comb begin
        decoded     = '0;
        known       = 1'b0;
        decoded.pc  = fetch_q.pc;
        decoded.rd  = instr[11:7];
        decoded.rs1 = instr[19:15];
        decoded.rs2 = instr[24:20];
        decoded.op1 = rs1_data;
        decoded.op2 = rs2_data;
        case (opcode)
            opc_op: begin
                known      = 1'b1;
                decoded.op = base_op(funct3, alt);
            end
            opc_op_imm: begin
                known       = 1'b1;
                decoded.op  = base_op(funct3, alt && (funct3 == 3'b101));
                decoded.op2 = imm_i;
                decoded.rs2 = '0;
            end
            opc_op_32: begin
                known        = word_f3_ok;
                decoded.op   = to_word(base_op(funct3, alt));
                decoded.word = 1'b1;
            end
            opc_op_imm_32: begin
                known        = word_f3_ok;
                decoded.op   = to_word(base_op(funct3, alt && (funct3 == 3'b101)));
                decoded.op2  = imm_i;
                decoded.rs2  = '0;
                decoded.word = 1'b1;
            end
            opc_lui: begin
                known       = 1'b1;
                decoded.op  = op_pass;
                decoded.op1 = '0;
                decoded.op2 = imm_u;
                decoded.rs1 = '0;
                decoded.rs2 = '0;
            end
            opc_auipc: begin
                known       = 1'b1;
                decoded.op  = op_add;
                decoded.op1 = fetch_q.pc;
                decoded.op2 = imm_u;
                decoded.rs1 = '0;
                decoded.rs2 = '0;
            end
            default: begin
                known = 1'b0;
            end
        endcase
        // x0 as destination never writes.
        decoded.rd_ena = known && (decoded.rd != '0);
        decoded.valid  = fetch_q.valid && known && !halted;
    end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [core_pkg::xlen-1:0] reset_pc = core_pkg::reset_pc
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       halt,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic                       wb_we,
    output logic [core_pkg::xlen-1:0]  wb_adr,
    input  logic                       wb_ack,
    input  logic [core_pkg::ilen-1:0]  wb_dat_i,
    output core_pkg::if_id_t           fetch
);
    import core_pkg::*;

    logic            req_q;
    logic [xlen-1:0] pc_q;

    // ########################################################################
    // request fsm.
    // ########################################################################

    // idle for one cycle between requests.
    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= 1'b0;
            pc_q  <= reset_pc;
        end else if (req_q) begin
            if (wb_ack) begin
                req_q <= 1'b0;
                pc_q  <= pc_q + 64'd4;
            end
        end else if (!halt) begin
            req_q <= 1'b1;
        end
    end

    assign wb_cyc = req_q;
    assign wb_stb = req_q;
    // read only.
    assign wb_we  = 1'b0;
    assign wb_adr = pc_q;

    // ########################################################################
    // fetched instruction.
    // ########################################################################

    always_comb begin
        fetch.valid = req_q && wb_ack;
        fetch.pc    = pc_q;
        fetch.instr = wb_dat_i;
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                       clk,
    input  logic                       reset,
    input  core_pkg::reg_addr_t        rs1_addr,
    input  core_pkg::reg_addr_t        rs2_addr,
    output logic [core_pkg::xlen-1:0]  rs1_data,
    output logic [core_pkg::xlen-1:0]  rs2_data,
    input  logic                       we,
    input  core_pkg::reg_addr_t        rd_addr,
    input  logic [core_pkg::xlen-1:0]  rd_data
);
    import core_pkg::*;

    logic [xlen-1:0] regs [1:31];

    // x0 reads zero, a same-cycle write is passed through.
    function automatic logic [xlen-1:0] read_port(input reg_addr_t addr);
        if (addr == '0) begin
            read_port = '0;
        end else if (we && (rd_addr == addr)) begin
            read_port = rd_data;
        end else begin
            read_port = regs[addr];
        end
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

endmodule

/* source/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // a bubble loads an empty payload, so its valid bit is low.
    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

/* tb.f */
+incdir+bench
source/core_pkg.sv
source/stage_reg.sv
source/fetch_unit.sv
source/decoder.sv
source/reg_file.sv
source/alu_execute.sv
source/core_top.sv
bench/core_tb.sv
